// ==== design/isa_pkg.sv ====
// ISA definitions for the microprogrammed execution unit
// instruction format, data width and opcode encoding
`default_nettype none

package isa_pkg;

	localparam int INSTR_W   = 16;
	localparam int DATA_W    = 16;
	localparam int NUM_REGS  = 4;
	localparam int REG_IDX_W = 2;

	// instruction field positions
	localparam int OPCODE_LSB = 12;
	localparam int OPCODE_W   = 4;
	localparam int RD_LSB     = 10;
	localparam int RS_LSB     = 8;
	localparam int IMM_LSB    = 0;
	localparam int IMM_W      = 8;
	localparam int SHAMT_W    = 4;   // low bits of imm8

	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	typedef enum logic [OPCODE_W-1:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_AND = 4'd2,
		OP_OR  = 4'd3,
		OP_XOR = 4'd4,
		OP_LDI = 4'd5,
		OP_SHL = 4'd6,
		OP_SHR = 4'd7,
		OP_MUL = 4'd8
	} opcode_t;   // codes 9 to 15 are illegal

endpackage

`default_nettype wire

// ==== design/ucode_pkg.sv ====
// Microcode definitions: microword layout, field encodings
// and the entry address of every routine in the microstore
`default_nettype none

package ucode_pkg;

	localparam int UADDR_W    = 7;
	localparam int UWORD_W    = 24;
	localparam int LOOP_CNT_W = 5;

	// microword field positions
	localparam int NEXT_SEL_LSB  = 22;
	localparam int NEXT_SEL_W    = 2;
	localparam int NEXT_ADDR_LSB = 15;
	localparam int NEXT_ADDR_W   = 7;
	localparam int ALU_OP_LSB    = 11;
	localparam int ALU_OP_W      = 4;
	localparam int SRC_B_LSB     = 9;
	localparam int SRC_B_W       = 2;
	localparam int CNT_LOAD_BIT  = 8;
	localparam int CNT_SRC_BIT   = 7;
	localparam int TMP_LOAD_BIT  = 6;
	localparam int MUL_INIT_BIT  = 5;
	localparam int MUL_STEP_BIT  = 4;
	localparam int REG_WRITE_BIT = 3;
	localparam int ILLEGAL_BIT   = 2;
	localparam int SPARE_LSB     = 0;
	localparam int SPARE_W       = 2;

	typedef enum logic [NEXT_SEL_W-1:0] {
		NX_SEQ  = 2'd0,
		NX_JUMP = 2'd1,
		NX_LOOP = 2'd2,
		NX_END  = 2'd3
	} next_sel_t;

	typedef enum logic [ALU_OP_W-1:0] {
		ALU_PASS_A = 4'd0,
		ALU_PASS_B = 4'd1,
		ALU_ADD    = 4'd2,
		ALU_SUB    = 4'd3,
		ALU_AND    = 4'd4,
		ALU_OR     = 4'd5,
		ALU_XOR    = 4'd6,
		ALU_SHL1   = 4'd7,
		ALU_SHR1   = 4'd8
	} alu_op_t;

	typedef enum logic [SRC_B_W-1:0] {
		SRC_RS    = 2'd0,
		SRC_IMM   = 2'd1,
		SRC_MCAND = 2'd2
	} src_b_t;

	typedef enum logic {
		CNT_SHAMT   = 1'b0,
		CNT_SIXTEEN = 1'b1
	} cnt_src_t;

	// address 0 holds the idle word
	localparam logic [UADDR_W-1:0] ENTRY_ADD     = 7'd1;
	localparam logic [UADDR_W-1:0] ENTRY_SUB     = 7'd3;
	localparam logic [UADDR_W-1:0] ENTRY_AND     = 7'd5;
	localparam logic [UADDR_W-1:0] ENTRY_OR      = 7'd7;
	localparam logic [UADDR_W-1:0] ENTRY_XOR     = 7'd9;
	localparam logic [UADDR_W-1:0] ENTRY_LDI     = 7'd11;
	localparam logic [UADDR_W-1:0] ENTRY_SHL     = 7'd13;
	localparam logic [UADDR_W-1:0] ENTRY_SHR     = 7'd16;
	localparam logic [UADDR_W-1:0] ENTRY_MUL     = 7'd19;
	localparam logic [UADDR_W-1:0] ENTRY_ILLEGAL = 7'd22;

endpackage

`default_nettype wire

// ==== design/instr_decode.sv ====
// Instruction decode: captures an accepted instruction, splits its fields
// and maps the opcode to the entry address of its microcode routine
`default_nettype none

module instr_decode (
	input  wire logic                            clk,
	input  wire logic                            reset,
	input  wire logic [isa_pkg::INSTR_W-1:0]     instr,
	input  wire logic                            instr_valid,
	input  wire logic                            ready,
	output logic                                 start,
	output logic [ucode_pkg::UADDR_W-1:0]        entry_addr,
	output isa_pkg::reg_idx_t                    rd,
	output isa_pkg::reg_idx_t                    rs,
	output logic [isa_pkg::IMM_W-1:0]            imm8,
	output logic [isa_pkg::SHAMT_W-1:0]          shamt
);
	import isa_pkg::*;
	import ucode_pkg::*;

	logic                 accept;
	opcode_t              opcode;
	logic [UADDR_W-1:0]   entry_next;

	assign accept = instr_valid && ready;
	assign opcode = opcode_t'(instr[OPCODE_LSB +: OPCODE_W]);

	always_comb begin
		case (opcode)
			OP_ADD:  entry_next = ENTRY_ADD;
			OP_SUB:  entry_next = ENTRY_SUB;
			OP_AND:  entry_next = ENTRY_AND;
			OP_OR:   entry_next = ENTRY_OR;
			OP_XOR:  entry_next = ENTRY_XOR;
			OP_LDI:  entry_next = ENTRY_LDI;
			OP_SHL:  entry_next = ENTRY_SHL;
			OP_SHR:  entry_next = ENTRY_SHR;
			OP_MUL:  entry_next = ENTRY_MUL;
			default: entry_next = ENTRY_ILLEGAL;   // codes outside the enum
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			start      <= 1'b0;
			entry_addr <= '0;
			rd         <= '0;
			rs         <= '0;
			imm8       <= '0;
			shamt      <= '0;
		end else begin
			start <= accept;
			if (accept) begin
				entry_addr <= entry_next;
				rd         <= instr[RD_LSB +: REG_IDX_W];
				rs         <= instr[RS_LSB +: REG_IDX_W];
				imm8       <= instr[IMM_LSB +: IMM_W];
				shamt      <= instr[IMM_LSB +: SHAMT_W];
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/microstore_rom.sv ====
// Control store: combinational table from micro-address to microword
`default_nettype none

module microstore_rom (
	input  wire logic [ucode_pkg::UADDR_W-1:0] index,
	output logic [ucode_pkg::UWORD_W-1:0]      out
);
	import ucode_pkg::*;

	// builds one microword from its fields
	function automatic logic [UWORD_W-1:0] pack(
		input next_sel_t          ns,
		input logic [UADDR_W-1:0] na,
		input alu_op_t            op,
		input src_b_t             sb,
		input logic               cnt_load,
		input cnt_src_t           cnt_src,
		input logic               tmp_load,
		input logic               mul_init,
		input logic               mul_step,
		input logic               reg_write,
		input logic               illegal
	);
		logic [UWORD_W-1:0] w;
		w = '0;
		w[NEXT_SEL_LSB +: NEXT_SEL_W]   = ns;
		w[NEXT_ADDR_LSB +: NEXT_ADDR_W] = na;
		w[ALU_OP_LSB +: ALU_OP_W]       = op;
		w[SRC_B_LSB +: SRC_B_W]         = sb;
		w[CNT_LOAD_BIT]                 = cnt_load;
		w[CNT_SRC_BIT]                  = cnt_src;
		w[TMP_LOAD_BIT]                 = tmp_load;
		w[MUL_INIT_BIT]                 = mul_init;
		w[MUL_STEP_BIT]                 = mul_step;
		w[REG_WRITE_BIT]                = reg_write;
		w[ILLEGAL_BIT]                  = illegal;
		w[SPARE_LSB +: SPARE_W]         = '0;
		return w;
	endfunction

	always_comb begin
		case (index)
			7'd1:  out = pack(NX_SEQ, 7'd0, ALU_ADD, SRC_RS, 0, CNT_SHAMT, 0, 0, 0, 1, 0);
			7'd2:  out = pack(NX_END, 7'd0, ALU_PASS_A, SRC_RS, 0, CNT_SHAMT, 0, 0, 0, 0, 0);
			7'd3:  out = pack(NX_SEQ, 7'd0, ALU_SUB, SRC_RS, 0, CNT_SHAMT, 0, 0, 0, 1, 0);
			7'd4:  out = pack(NX_END, 7'd0, ALU_PASS_A, SRC_RS, 0, CNT_SHAMT, 0, 0, 0, 0, 0);
			7'd5:  out = pack(NX_SEQ, 7'd0, ALU_AND, SRC_RS, 0, CNT_SHAMT, 0, 0, 0, 1, 0);
			7'd6:  out = pack(NX_END, 7'd0, ALU_PASS_A, SRC_RS, 0, CNT_SHAMT, 0, 0, 0, 0, 0);
			7'd7:  out = pack(NX_SEQ, 7'd0, ALU_OR, SRC_RS, 0, CNT_SHAMT, 0, 0, 0, 1, 0);
			7'd8:  out = pack(NX_END, 7'd0, ALU_PASS_A, SRC_RS, 0, CNT_SHAMT, 0, 0, 0, 0, 0);
			7'd9:  out = pack(NX_SEQ, 7'd0, ALU_XOR, SRC_RS, 0, CNT_SHAMT, 0, 0, 0, 1, 0);
			7'd10: out = pack(NX_END, 7'd0, ALU_PASS_A, SRC_RS, 0, CNT_SHAMT, 0, 0, 0, 0, 0);
			7'd11: out = pack(NX_SEQ, 7'd0, ALU_PASS_B, SRC_IMM, 0, CNT_SHAMT, 0, 0, 0, 1, 0);
			7'd12: out = pack(NX_END, 7'd0, ALU_PASS_A, SRC_RS, 0, CNT_SHAMT, 0, 0, 0, 0, 0);
			// shift left, rd copied to tmp while the count is loaded
			7'd13: out = pack(NX_SEQ, 7'd0, ALU_PASS_A, SRC_RS, 1, CNT_SHAMT, 1, 0, 0, 0, 0);
			7'd14: out = pack(NX_LOOP, 7'd14, ALU_SHL1, SRC_RS, 0, CNT_SHAMT, 1, 0, 0, 0, 0);
			7'd15: out = pack(NX_END, 7'd0, ALU_PASS_A, SRC_RS, 0, CNT_SHAMT, 0, 0, 0, 1, 0);
			7'd16: out = pack(NX_SEQ, 7'd0, ALU_PASS_A, SRC_RS, 1, CNT_SHAMT, 1, 0, 0, 0, 0);
			7'd17: out = pack(NX_LOOP, 7'd17, ALU_SHR1, SRC_RS, 0, CNT_SHAMT, 1, 0, 0, 0, 0);
			7'd18: out = pack(NX_END, 7'd0, ALU_PASS_A, SRC_RS, 0, CNT_SHAMT, 0, 0, 0, 1, 0);
			// multiply accumulates the product in tmp
			7'd19: out = pack(NX_SEQ, 7'd0, ALU_PASS_A, SRC_RS, 1, CNT_SIXTEEN, 0, 1, 0, 0, 0);
			7'd20: out = pack(NX_LOOP, 7'd20, ALU_ADD, SRC_MCAND, 0, CNT_SHAMT, 0, 0, 1, 0, 0);
			7'd21: out = pack(NX_END, 7'd0, ALU_PASS_A, SRC_RS, 0, CNT_SHAMT, 0, 0, 0, 1, 0);
			7'd22: out = pack(NX_END, 7'd0, ALU_PASS_A, SRC_RS, 0, CNT_SHAMT, 0, 0, 0, 0, 1);
			default: out = '0;   // idle word, no control active
		endcase
	end

endmodule

`default_nettype wire

// ==== design/micro_sequencer.sv ====
// Micro sequencer: micro-program counter, loop counter and next-address
// selection, with a pulse at the end of each routine
`default_nettype none

module micro_sequencer (
	input  wire logic                            clk,
	input  wire logic                            reset,
	input  wire logic                            start,
	input  wire logic [ucode_pkg::UADDR_W-1:0]   entry_addr,
	input  wire logic [ucode_pkg::UWORD_W-1:0]   uword,
	input  wire logic [isa_pkg::SHAMT_W-1:0]     shamt,
	output logic [ucode_pkg::UADDR_W-1:0]        upc,
	output logic                                 busy,
	output logic                                 uword_end
);
	import ucode_pkg::*;

	logic                  running;
	logic [LOOP_CNT_W-1:0] loop_cnt;
	next_sel_t             next_sel;
	logic [UADDR_W-1:0]    next_addr;
	cnt_src_t              cnt_src;
	logic                  cnt_load;

	assign next_sel  = next_sel_t'(uword[NEXT_SEL_LSB +: NEXT_SEL_W]);
	assign next_addr = uword[NEXT_ADDR_LSB +: NEXT_ADDR_W];
	assign cnt_src   = cnt_src_t'(uword[CNT_SRC_BIT]);
	assign cnt_load  = uword[CNT_LOAD_BIT];

	assign busy      = running || start;   // ready drops the cycle after acceptance
	assign uword_end = running && (next_sel == NX_END);

	always_ff @(posedge clk) begin
		if (reset) begin
			upc      <= '0;
			running  <= 1'b0;
			loop_cnt <= '0;
		end else if (start) begin
			upc     <= entry_addr;
			running <= 1'b1;
		end else if (running) begin
			case (next_sel)
				NX_SEQ:  upc <= upc + 1'b1;
				NX_JUMP: upc <= next_addr;
				NX_LOOP: begin
					if (loop_cnt != '0) begin
						loop_cnt <= loop_cnt - 1'b1;
						upc      <= next_addr;
					end else begin
						upc <= upc + 1'b1;
					end
				end
				NX_END: begin
					upc     <= '0;   // park on the idle word
					running <= 1'b0;
				end
				default: upc <= '0;
			endcase
			if (cnt_load)
				loop_cnt <= (cnt_src == CNT_SIXTEEN) ? LOOP_CNT_W'(16) : LOOP_CNT_W'(shamt);
		end
	end

endmodule

`default_nettype wire

// ==== design/alu_datapath.sv ====
// Datapath: register file, temporary and multiplier registers and the ALU,
// all steered by the current microword
`default_nettype none

module alu_datapath (
	input  wire logic                            clk,
	input  wire logic                            reset,
	input  wire logic [ucode_pkg::UWORD_W-1:0]   uword,
	input  wire isa_pkg::reg_idx_t               rd,
	input  wire isa_pkg::reg_idx_t               rs,
	input  wire logic [isa_pkg::IMM_W-1:0]       imm8,
	output logic [isa_pkg::DATA_W-1:0]           wr_data,
	output logic                                 wr_en
);
	import isa_pkg::*;
	import ucode_pkg::*;

	logic [DATA_W-1:0] regs [NUM_REGS];
	logic [DATA_W-1:0] tmp;
	logic [DATA_W-1:0] mcand;
	logic [DATA_W-1:0] mplier;
	logic              tmp_valid;
	logic              prev_loop;

	next_sel_t         next_sel;
	alu_op_t           alu_op;
	src_b_t            src_b;
	logic              tmp_load;
	logic              mul_init;
	logic              mul_step;
	logic              loop_first;
	logic [DATA_W-1:0] a_op;
	logic [DATA_W-1:0] b_op;
	logic [DATA_W-1:0] alu_y;

	assign next_sel = next_sel_t'(uword[NEXT_SEL_LSB +: NEXT_SEL_W]);
	assign alu_op   = alu_op_t'(uword[ALU_OP_LSB +: ALU_OP_W]);
	assign src_b    = src_b_t'(uword[SRC_B_LSB +: SRC_B_W]);
	assign tmp_load = uword[TMP_LOAD_BIT];
	assign mul_init = uword[MUL_INIT_BIT];
	assign mul_step = uword[MUL_STEP_BIT];

	// a loop word runs count+1 times, its first pass only waits
	assign loop_first = (next_sel == NX_LOOP) && !prev_loop;

	assign a_op = tmp_valid ? tmp : regs[rd];

	always_comb begin
		case (src_b)
			SRC_RS:    b_op = regs[rs];
			SRC_IMM:   b_op = DATA_W'(imm8);
			SRC_MCAND: b_op = mcand;
			default:   b_op = '0;
		endcase
	end

	always_comb begin
		case (alu_op)
			ALU_PASS_A: alu_y = a_op;
			ALU_PASS_B: alu_y = b_op;
			ALU_ADD:    alu_y = a_op + b_op;
			ALU_SUB:    alu_y = a_op - b_op;
			ALU_AND:    alu_y = a_op & b_op;
			ALU_OR:     alu_y = a_op | b_op;
			ALU_XOR:    alu_y = a_op ^ b_op;
			ALU_SHL1:   alu_y = a_op << 1;
			ALU_SHR1:   alu_y = a_op >> 1;
			default:    alu_y = '0;
		endcase
	end

	assign wr_data = alu_y;
	assign wr_en   = uword[REG_WRITE_BIT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
			tmp       <= '0;
			mcand     <= '0;
			mplier    <= '0;
			tmp_valid <= 1'b0;
			prev_loop <= 1'b0;
		end else begin
			prev_loop <= (next_sel == NX_LOOP);
			if (wr_en)
				regs[rd] <= alu_y;
			if (mul_init) begin
				tmp       <= '0;   // product starts empty
				mcand     <= regs[rd];
				mplier    <= regs[rs];
				tmp_valid <= 1'b1;
			end else if (mul_step && !loop_first) begin
				if (mplier[0])
					tmp <= alu_y;
				mcand  <= mcand << 1;
				mplier <= mplier >> 1;
			end
			if (tmp_load && !loop_first) begin
				tmp       <= alu_y;
				tmp_valid <= 1'b1;
			end
			if (next_sel == NX_END)
				tmp_valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== design/result_stage.sv ====
// Result stage: holds the last written value and presents it with the
// zero and illegal flags and a one-cycle done pulse
`default_nettype none

module result_stage (
	input  wire logic                         clk,
	input  wire logic                         reset,
	input  wire logic [isa_pkg::DATA_W-1:0]   wr_data,
	input  wire logic                         wr_en,
	input  wire isa_pkg::reg_idx_t            rd,
	input  wire logic                         uword_end,
	input  wire logic                         illegal_bit,
	output logic                              done,
	output logic [isa_pkg::DATA_W-1:0]        result,
	output isa_pkg::reg_idx_t                 result_reg,
	output logic                              zero,
	output logic                              illegal
);
	import isa_pkg::*;

	logic [DATA_W-1:0] last_val;
	reg_idx_t          last_reg;
	logic [DATA_W-1:0] cur_val;
	reg_idx_t          cur_reg;

	// the write may land in the same cycle as the end word
	assign cur_val = wr_en ? wr_data : last_val;
	assign cur_reg = wr_en ? rd : last_reg;

	always_ff @(posedge clk) begin
		if (reset) begin
			last_val <= '0;
			last_reg <= '0;
		end else if (wr_en) begin
			last_val <= wr_data;
			last_reg <= rd;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			done       <= 1'b0;
			result     <= '0;
			result_reg <= '0;
			zero       <= 1'b0;
			illegal    <= 1'b0;
		end else begin
			done <= uword_end;
			if (uword_end) begin
				result     <= illegal_bit ? '0 : cur_val;
				result_reg <= illegal_bit ? rd : cur_reg;
				zero       <= illegal_bit || (cur_val == '0);
				illegal    <= illegal_bit;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/ucode_cpu_top.sv ====
// Microprogrammed execution unit top level
// connects decode, sequencer, control store, datapath and result stage
`default_nettype none

module ucode_cpu_top (
	input  wire logic                         clk,
	input  wire logic                         reset,
	input  wire logic [isa_pkg::INSTR_W-1:0]  instr,
	input  wire logic                         instr_valid,
	output logic                              ready,
	output logic                              done,
	output logic [isa_pkg::DATA_W-1:0]        result,
	output isa_pkg::reg_idx_t                 result_reg,
	output logic                              zero,
	output logic                              illegal
);
	import isa_pkg::*;
	import ucode_pkg::*;

	logic               start;
	logic [UADDR_W-1:0] entry_addr;
	reg_idx_t           rd;
	reg_idx_t           rs;
	logic [IMM_W-1:0]   imm8;
	logic [SHAMT_W-1:0] shamt;
	logic [UADDR_W-1:0] upc;
	logic [UWORD_W-1:0] uword;
	logic               busy;
	logic               uword_end;
	logic [DATA_W-1:0]  wr_data;
	logic               wr_en;
	logic               illegal_bit;

	assign ready       = !busy;
	assign illegal_bit = uword[ILLEGAL_BIT];

	instr_decode u_decode (
		.clk(clk), .reset(reset), .instr(instr), .instr_valid(instr_valid),
		.ready(ready), .start(start), .entry_addr(entry_addr),
		.rd(rd), .rs(rs), .imm8(imm8), .shamt(shamt)
	);

	micro_sequencer u_seq (
		.clk(clk), .reset(reset), .start(start), .entry_addr(entry_addr),
		.uword(uword), .shamt(shamt), .upc(upc), .busy(busy), .uword_end(uword_end)
	);

	microstore_rom u_rom (.index(upc), .out(uword));

	alu_datapath u_dp (
		.clk(clk), .reset(reset), .uword(uword), .rd(rd), .rs(rs),
		.imm8(imm8), .wr_data(wr_data), .wr_en(wr_en)
	);

	result_stage u_result (
		.clk(clk), .reset(reset), .wr_data(wr_data), .wr_en(wr_en), .rd(rd),
		.uword_end(uword_end), .illegal_bit(illegal_bit), .done(done),
		.result(result), .result_reg(result_reg), .zero(zero), .illegal(illegal)
	);

endmodule

`default_nettype wire

// ==== dv/ucode_cpu_checker.sv ====
// Protocol checker for the execution unit, bound to the top level
// covers the done pulse, ready around an accepted instruction and reset values
`default_nettype none

module ucode_cpu_checker (
	input wire logic                        clk,
	input wire logic                        reset,
	input wire logic                        instr_valid,
	input wire logic                        ready,
	input wire logic                        done,
	input wire logic                        zero,
	input wire logic                        illegal,
	input wire logic [isa_pkg::DATA_W-1:0]  result
);

	done_one_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("done stayed high for more than one cycle");

	ready_drops: assert property (@(posedge clk) disable iff (reset)
		(instr_valid && ready) |=> !ready)
		else $error("ready stayed high after an accepted instruction");

	// ready only comes back together with done
	ready_rises_with_done: assert property (@(posedge clk) disable iff (reset)
		$rose(ready) |-> done)
		else $error("ready rose without done");

	done_rises_with_ready: assert property (@(posedge clk) disable iff (reset)
		$rose(done) |-> $rose(ready))
		else $error("done rose while ready did not");

	quiet_after_reset: assert property (@(posedge clk)
		reset |=> (ready && !done && !illegal && !zero && result == '0))
		else $error("outputs not at their idle values after reset");

endmodule

bind ucode_cpu_top ucode_cpu_checker u_checker (
	.clk(clk), .reset(reset), .instr_valid(instr_valid), .ready(ready),
	.done(done), .zero(zero), .illegal(illegal), .result(result)
);

`default_nettype wire

// ==== dv/ucode_cpu_tb.sv ====
// Testbench for the microprogrammed execution unit
// random instructions checked against a register file model
`default_nettype none

module ucode_cpu_tb;
	import isa_pkg::*;

	localparam int TIMEOUT = 200;

	logic               clk;
	logic               reset;
	logic [INSTR_W-1:0] instr;
	logic               instr_valid;
	logic               ready;
	logic               done;
	logic [DATA_W-1:0]  result;
	reg_idx_t           result_reg;
	logic               zero;
	logic               illegal;

	logic [DATA_W-1:0]  model_regs [NUM_REGS];
	logic [19:0]        exp_q [$];   // {illegal, zero, result_reg, result}
	int                 lat_q [$];   // 0 when the latency is not fixed
	int                 seed = 32'ha396;
	int                 cycle;
	int                 accept_cycle;
	int                 checks;
	int                 errors;
	logic               timed_out;

	ucode_cpu_top dut (
		.clk(clk), .reset(reset), .instr(instr), .instr_valid(instr_valid),
		.ready(ready), .done(done), .result(result), .result_reg(result_reg),
		.zero(zero), .illegal(illegal)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	function automatic logic [INSTR_W-1:0] make_instr(input logic [3:0] op,
		input reg_idx_t rd, input reg_idx_t rs, input logic [7:0] imm);
		return {op, rd, rs, imm};
	endfunction

	// runs one instruction on the register model and returns the expected outputs
	function automatic logic [19:0] predict(input logic [INSTR_W-1:0] ins);
		reg_idx_t          rd;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] y;
		rd = ins[11:10];
		a  = model_regs[rd];
		b  = model_regs[ins[9:8]];
		case (ins[15:12])
			OP_ADD:  y = a + b;
			OP_SUB:  y = a - b;
			OP_AND:  y = a & b;
			OP_OR:   y = a | b;
			OP_XOR:  y = a ^ b;
			OP_LDI:  y = {8'h00, ins[7:0]};
			OP_SHL:  y = a << ins[3:0];
			OP_SHR:  y = a >> ins[3:0];
			OP_MUL:  y = a * b;   // low half of the product
			default: return {1'b1, 1'b1, rd, 16'h0000};
		endcase
		model_regs[rd] = y;
		return {1'b0, y == '0, rd, y};
	endfunction

	task automatic report_mismatch(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] want);
		$display("MISMATCH %s: got %h, expected %h", name, got, want);
		errors++;
	endtask

	// compares every completed instruction with the model
	always @(negedge clk) begin
		logic [19:0] want;
		int          lat;
		if (!reset && instr_valid && ready)
			accept_cycle = cycle;
		if (!reset && done) begin
			assert (exp_q.size() != 0) else begin
				$display("done pulsed with no instruction outstanding");
				errors++;
			end
			if (exp_q.size() != 0) begin
				want = exp_q.pop_front();
				lat  = lat_q.pop_front();
				checks++;
				assert (result == want[15:0]) else report_mismatch("result", result, want[15:0]);
				assert (result_reg == want[17:16])
					else report_mismatch("result_reg", 16'(result_reg), 16'(want[17:16]));
				assert (zero == want[18]) else report_mismatch("zero", 16'(zero), 16'(want[18]));
				assert (illegal == want[19])
					else report_mismatch("illegal", 16'(illegal), 16'(want[19]));
				assert (lat == 0 || cycle - accept_cycle == lat) else begin
					$display("done came %0d cycles after acceptance instead of %0d",
						cycle - accept_cycle, lat);
					errors++;
				end
			end
		end
	end

	// later waits are skipped so the run reaches its verdict quickly
	task automatic flag_timeout(input string what);
		$display("timeout: %s", what);
		errors++;
		timed_out = 1'b1;
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		if (timed_out)
			return;
		@(negedge clk);
		while (!ready && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!ready)
			flag_timeout("ready never returned high");
	endtask

	task automatic wait_checked();
		int n;
		n = 0;
		if (timed_out)
			return;
		while (exp_q.size() != 0 && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() != 0)
			flag_timeout("no done pulse for the last instruction");
	endtask

	task automatic queue_expected(input logic [INSTR_W-1:0] ins);
		exp_q.push_back(predict(ins));
		lat_q.push_back((ins[15:12] <= OP_LDI) ? 4 : 0);   // one-word routines
	endtask

	task automatic strobe(input logic [INSTR_W-1:0] ins);
		@(posedge clk);
		instr       <= ins;
		instr_valid <= 1'b1;
		@(posedge clk);
		instr_valid <= 1'b0;
	endtask

	task automatic issue(input logic [INSTR_W-1:0] ins);
		wait_ready();
		queue_expected(ins);
		strobe(ins);
		wait_checked();
	endtask

	// builds 0, 1 or 16'hffff in a register with r3 holding one
	task automatic load_edge(input reg_idx_t r, input int kind);
		issue(make_instr(OP_LDI, r, 2'd0, 8'h00));
		if (kind == 1)
			issue(make_instr(OP_ADD, r, 2'd3, 8'h00));
		else if (kind == 2)
			issue(make_instr(OP_SUB, r, 2'd3, 8'h00));
	endtask

	task automatic report_test(input string name, input int first);
		$display("test %s finished with %0d errors", name, errors - first);
	endtask

	initial begin
		int          first;
		logic [31:0] rnd;
		logic [3:0]  amt;
		clk         = 1'b0;
		reset       = 1'b1;
		instr       = '0;
		instr_valid = 1'b0;
		checks      = 0;
		errors      = 0;
		timed_out   = 1'b0;
		for (int r = 0; r < NUM_REGS; r++)
			model_regs[r] = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		first = errors;
		for (int r = 0; r < NUM_REGS; r++) begin
			rnd = $random(seed);
			issue(make_instr(OP_LDI, 2'(r), 2'd0, rnd[7:0]));
		end
		for (int i = 0; i < 40; i++) begin
			rnd = $random(seed);
			issue(make_instr(4'(rnd[18:16] % 5), rnd[11:10], rnd[9:8], rnd[7:0]));
		end
		report_test("alu", first);

		first = errors;
		for (int i = 0; i < 16; i++) begin
			rnd = $random(seed);
			amt = (i < 2) ? 4'd0 : (i < 4) ? 4'd15 : rnd[23:20];
			issue(make_instr(OP_LDI, rnd[11:10], 2'd0, rnd[7:0]));
			if (i[0])
				issue(make_instr(OP_SHL, rnd[11:10], 2'd0, 8'h08));   // fill the upper byte
			issue(make_instr(i[0] ? OP_SHR : OP_SHL, rnd[11:10], rnd[9:8], {rnd[15:12], amt}));
		end
		report_test("shift", first);

		first = errors;
		issue(make_instr(OP_LDI, 2'd3, 2'd0, 8'h01));
		for (int a = 0; a < 3; a++) begin
			for (int b = 0; b < 3; b++) begin
				load_edge(2'd1, a);
				load_edge(2'd2, b);
				issue(make_instr(OP_MUL, 2'd1, 2'd2, 8'h00));
			end
		end
		for (int i = 0; i < 10; i++) begin
			rnd = $random(seed);
			issue(make_instr(OP_LDI, 2'd1, 2'd0, rnd[7:0]));
			issue(make_instr(OP_LDI, 2'd2, 2'd0, rnd[15:8]));
			issue(make_instr(OP_SHL, 2'd1, 2'd0, {4'h0, rnd[19:16]}));
			issue(make_instr(OP_MUL, 2'd1, 2'd2, 8'h00));
		end
		issue(make_instr(OP_MUL, 2'd0, 2'd0, 8'h00));
		report_test("multiply", first);

		first = errors;
		for (int c = 9; c < 16; c++) begin
			rnd = $random(seed);
			issue(make_instr(4'(c), rnd[11:10], rnd[9:8], rnd[7:0]));
		end
		issue(make_instr(OP_ADD, 2'd0, 2'd1, 8'h00));
		for (int r = 0; r < NUM_REGS; r++)
			issue(make_instr(OP_OR, 2'(r), 2'(r), 8'h00));   // reads a register back
		report_test("illegal", first);

		first = errors;
		wait_ready();
		queue_expected(make_instr(OP_MUL, 2'd1, 2'd2, 8'h00));
		strobe(make_instr(OP_MUL, 2'd1, 2'd2, 8'h00));
		@(negedge clk);
		assert (!ready) else begin
			$display("ready was high while a multiply was running");
			errors++;
		end
		strobe(make_instr(OP_LDI, 2'd1, 2'd0, 8'h5a));   // lands while busy
		wait_checked();
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			assert (!done) else begin
				$display("done pulsed for a strobe sent while busy");
				errors++;
			end
		end
		issue(make_instr(OP_OR, 2'd1, 2'd1, 8'h00));
		report_test("busy_strobe", first);

		first = errors;
		for (int r = 0; r < NUM_REGS; r++) begin
			rnd = $random(seed);
			issue(make_instr(OP_SUB, 2'(r), 2'(r), 8'h00));
			issue(make_instr(OP_LDI, 2'(r), 2'd0, rnd[7:0] | 8'h01));
		end
		report_test("zero_flag", first);

		$display("%0d instructions checked, %0d errors", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== ucode_cpu.f ====
design/isa_pkg.sv
design/ucode_pkg.sv
design/instr_decode.sv
design/microstore_rom.sv
design/micro_sequencer.sv
design/alu_datapath.sv
design/result_stage.sv
design/ucode_cpu_top.sv
dv/ucode_cpu_checker.sv
dv/ucode_cpu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = ucode_cpu_tb
FILELIST  = ucode_cpu.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "No errors" $(LOG) || { echo "FAIL: run ended without a verdict"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
